// File: src/robDefines.svh
// Sizing macros for the reorder buffer, included by every RTL file and the testbench
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// Entry number width, log2 of the depth (2, 3 or 4 all work)
`define ROB_TAG_W 3

// Number of entries
`define ROB_DEPTH (1 << `ROB_TAG_W)

// Data and address width
`define XLEN 32

// Gshare pattern history table index width
`define PHT_INDEX_W 8

// Architectural destination register number
`define ARCH_REG_W 5

`endif

// File: src/robPkg.sv
// Reorder buffer record types for allocation from rename and for the commit output
`include "robDefines.svh"

package robPkg;

  // Entry number, also the tag that travels with an instruction
  typedef logic [`ROB_TAG_W-1:0] robTagT;

  // Control bits decoded in rename
  typedef struct packed {
    logic regWrite;  // Writes the register file at commit
    logic memWrite;  // Store, memory is written at commit
    logic branch;    // Conditional branch
    logic jump;      // JAL or JALR
  } robCtrlT;

  // Fields written by rename when an entry is allocated
  typedef struct packed {
    logic [`ARCH_REG_W-1:0]  destReg;   // Destination register
    logic [`XLEN-1:0]        instrPc;   // PC of the instruction, for the BTB update
    logic [`PHT_INDEX_W-1:0] phtIndex;  // Gshare index used at fetch
    robCtrlT                 ctrl;
  } robAllocT;

  // One retired instruction as seen by the register file and predictor
  typedef struct packed {
    logic                    valid;          // High one cycle per committed entry
    robTagT                  tag;            // Entry that committed
    logic [`ARCH_REG_W-1:0]  destReg;
    robCtrlT                 ctrl;
    logic [`XLEN-1:0]        result;
    logic [`XLEN-1:0]        instrPc;
    logic [`PHT_INDEX_W-1:0] phtIndex;
    logic                    isControl;      // Control-flow instruction
    logic                    taken;          // Resolved direction
    logic                    mispredict;     // Fetch went the wrong way
    logic [`XLEN-1:0]        targetAddress;  // Resolved target
  } robCommitT;

endpackage

// File: src/cdbPkg.sv
// Common data bus broadcast type, shared by the reorder buffer and its producers
`include "robDefines.svh"

package cdbPkg;

  // One result broadcast per cycle from the execution units
  typedef struct packed {
    logic                  valid;          // Broadcast strobe
    logic [`ROB_TAG_W-1:0] tag;            // Destination entry in the reorder buffer
    logic [`XLEN-1:0]      result;         // Computed value
    logic                  isControl;      // Branch or jump
    logic                  taken;          // Branch outcome
    logic                  mispredict;     // Prediction was wrong
    logic [`XLEN-1:0]      targetAddress;  // Correct fetch address
  } cdbBroadcastT;

endpackage

// File: src/robAllocator.sv
// Tail pointer and occupancy of the reorder buffer, gives the next tag and the full flag
`timescale 1ns/1ns
`include "robDefines.svh"

module robAllocator (
  input  logic           clk,
  input  logic           reset,       // Active low, synchronous
  input  logic           allocValid,  // Rename wants an entry
  input  logic           commitFire,  // Head retires at this edge
  input  logic           flush,       // Mispredicted commit at this edge
  input  robPkg::robTagT headTag,
  output robPkg::robTagT allocTag,    // Entry the next allocation receives
  output logic           allocFire,
  output logic           full,
  output logic           empty
);

  robPkg::robTagT      tail;
  logic [`ROB_TAG_W:0] count;  // One bit wider so all entries are usable

  assign allocTag  = tail;
  assign full      = (count == `ROB_DEPTH);
  assign empty     = (count == '0);
  assign allocFire = allocValid & ~full;  // Requests while full are dropped

  always_ff @(posedge clk) begin
    if (!reset) begin
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      // Everything younger than the committing head is discarded
      tail  <= robPkg::robTagT'(headTag + 1'b1);
      count <= '0;
    end else begin
      if (allocFire) begin
        tail <= robPkg::robTagT'(tail + 1'b1);  // Wraps at depth
      end
      case ({allocFire, commitFire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither, occupancy holds
      endcase
    end
  end

  // Occupancy never wraps below zero, commit only retires a held entry
  occupancyBound: assert property (
    @(posedge clk) disable iff (!reset)
    commitFire |-> count != '0
  ) else $error("ROB commit with occupancy %0d", count);

endmodule

// File: src/robStorage.sv
// Entry arrays of the reorder buffer with ready bits, head read and two operand lookups
`timescale 1ns/1ns
`include "robDefines.svh"

module robStorage (
  input  logic                 clk,
  input  logic                 reset,       // Active low, clears ready bits only
  input  logic                 allocFire,
  input  robPkg::robTagT       allocTag,
  input  robPkg::robAllocT     allocData,
  input  cdbPkg::cdbBroadcastT cdb,
  input  logic                 commitFire,
  input  robPkg::robTagT       headTag,
  input  robPkg::robTagT       lookupTag1,
  input  robPkg::robTagT       lookupTag2,
  output robPkg::robCommitT    headEntry,   // Valid is the stored ready bit
  output logic [`XLEN-1:0]     lookupValue1,
  output logic                 lookupValid1,
  output logic [`XLEN-1:0]     lookupValue2,
  output logic                 lookupValid2
);

  // Rename-time fields
  robPkg::robAllocT allocMem [`ROB_DEPTH];

  // Execution-time fields, filled from the CDB
  logic [`XLEN-1:0] resultMem [`ROB_DEPTH];
  logic [`XLEN-1:0] targetMem [`ROB_DEPTH];
  logic             isControlMem [`ROB_DEPTH];
  logic             takenMem [`ROB_DEPTH];
  logic             mispredictMem [`ROB_DEPTH];

  logic [`ROB_DEPTH-1:0] ready;  // Result present, entry may commit

  // True when the CDB carries this tag in the current cycle
  function automatic logic cdbHit(input cdbPkg::cdbBroadcastT bus, input robPkg::robTagT tag);
    return bus.valid && (bus.tag == tag);
  endfunction

  always_ff @(posedge clk) begin
    if (allocFire) begin
      allocMem[allocTag] <= allocData;
    end
    if (cdb.valid) begin  // Different entry from allocation, see check below
      resultMem[cdb.tag]     <= cdb.result;
      targetMem[cdb.tag]     <= cdb.targetAddress;
      isControlMem[cdb.tag]  <= cdb.isControl;
      takenMem[cdb.tag]      <= cdb.taken;
      mispredictMem[cdb.tag] <= cdb.mispredict;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      ready <= '0;
    end else begin
      if (allocFire) ready[allocTag] <= 1'b0;  // Stale result from the last lap
      if (cdb.valid) ready[cdb.tag] <= 1'b1;
      // Last so a bypassed commit leaves the entry not ready
      if (commitFire) ready[headTag] <= 1'b0;
    end
  end

  always_comb begin
    headEntry               = '0;
    headEntry.valid         = ready[headTag];
    headEntry.tag           = headTag;
    headEntry.destReg       = allocMem[headTag].destReg;
    headEntry.ctrl          = allocMem[headTag].ctrl;
    headEntry.instrPc       = allocMem[headTag].instrPc;
    headEntry.phtIndex      = allocMem[headTag].phtIndex;
    headEntry.result        = resultMem[headTag];
    headEntry.isControl     = isControlMem[headTag];
    headEntry.taken         = takenMem[headTag];
    headEntry.mispredict    = mispredictMem[headTag];
    headEntry.targetAddress = targetMem[headTag];
  end

  // Operand lookups, CDB value wins over the stored one
  assign lookupValue1 = cdbHit(cdb, lookupTag1) ? cdb.result : resultMem[lookupTag1];
  assign lookupValid1 = ready[lookupTag1] | cdbHit(cdb, lookupTag1);
  assign lookupValue2 = cdbHit(cdb, lookupTag2) ? cdb.result : resultMem[lookupTag2];
  assign lookupValid2 = ready[lookupTag2] | cdbHit(cdb, lookupTag2);

  // An instruction cannot broadcast before rename has allocated its entry
  cdbNotOnAlloc: assert property (
    @(posedge clk) disable iff (!reset)
    !(allocFire && cdbHit(cdb, allocTag))
  ) else $error("CDB write to entry %0d while it is allocated", allocTag);

endmodule

// File: src/robCommit.sv
// In-order retirement from the reorder buffer head, with CDB bypass and flush request
`timescale 1ns/1ns
`include "robDefines.svh"

module robCommit (
  input  logic                 clk,
  input  logic                 reset,       // Active low, synchronous
  input  robPkg::robCommitT    headEntry,   // Combinational read of the head entry
  input  cdbPkg::cdbBroadcastT cdb,
  input  logic                 empty,
  output robPkg::robTagT       headTag,
  output logic                 commitFire,
  output logic                 flush,
  output robPkg::robCommitT    commit       // Registered commit record
);

  logic              headBypass;  // CDB is writing the head this cycle
  logic              headReady;
  robPkg::robCommitT nextRecord;

  assign headBypass = cdb.valid && (cdb.tag == headTag);
  assign headReady  = headEntry.valid | headBypass;
  assign commitFire = headReady & ~empty;

  // Head entry with the fresh CDB fields swapped in on a bypass
  always_comb begin
    nextRecord       = headEntry;
    nextRecord.valid = 1'b1;
    if (headBypass) begin
      nextRecord.result        = cdb.result;
      nextRecord.isControl     = cdb.isControl;
      nextRecord.taken         = cdb.taken;
      nextRecord.mispredict    = cdb.mispredict;
      nextRecord.targetAddress = cdb.targetAddress;
    end
  end

  assign flush = commitFire & nextRecord.mispredict;  // Same edge as the commit

  always_ff @(posedge clk) begin
    if (!reset) begin
      headTag <= '0;
      commit  <= '0;
    end else if (commitFire) begin
      headTag <= robPkg::robTagT'(headTag + 1'b1);
      commit  <= nextRecord;
    end else begin
      // Idle cycle, drop anything that changes architectural state
      commit.valid      <= 1'b0;
      commit.ctrl       <= '0;
      commit.isControl  <= 1'b0;
      commit.taken      <= 1'b0;
      commit.mispredict <= 1'b0;
    end
  end

  // Flush empties the buffer, so nothing commits on the edge after it
  noCommitAfterFlush: assert property (
    @(posedge clk) disable iff (!reset)
    flush |=> empty && !commitFire
  ) else $error("Commit from entry %0d right after a flush", headTag);

endmodule

// File: src/reorderBuffer.sv
// Reorder buffer top level, connects allocator, entry storage and commit logic
`timescale 1ns/1ns
`include "robDefines.svh"

module reorderBuffer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 allocValid,    // Rename allocates one entry
  input  robPkg::robAllocT     allocData,
  input  cdbPkg::cdbBroadcastT cdb,
  input  robPkg::robTagT       lookupTag1,
  input  robPkg::robTagT       lookupTag2,
  output robPkg::robTagT       allocTag,
  output logic                 full,
  output logic [`XLEN-1:0]     lookupValue1,
  output logic                 lookupValid1,
  output logic [`XLEN-1:0]     lookupValue2,
  output logic                 lookupValid2,
  output robPkg::robCommitT    commit
);

  logic              allocFire;
  logic              empty;
  logic              commitFire;
  logic              flush;
  robPkg::robTagT    headTag;
  robPkg::robCommitT headEntry;

  robAllocator allocator0 (
    .clk, .reset, .allocValid, .commitFire, .flush, .headTag,
    .allocTag, .allocFire, .full, .empty
  );

  robStorage storage0 (
    .clk, .reset, .allocFire, .allocTag, .allocData, .cdb, .commitFire, .headTag,
    .lookupTag1, .lookupTag2, .headEntry,
    .lookupValue1, .lookupValid1, .lookupValue2, .lookupValid2
  );

  robCommit commit0 (
    .clk, .reset, .headEntry, .cdb, .empty,
    .headTag, .commitFire, .flush, .commit
  );

endmodule

// File: dv/robClockGen.sv
// Testbench clock of 20 ns period and an active-low reset held for the first 3 cycles
`timescale 1ns/1ns

module robClockGen (
  output logic clk,
  output logic reset  // Active low
);

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  initial begin
    reset = 1'b0;
    repeat (3) @(posedge clk);
    #2 reset = 1'b1;  // Released just after the third edge, like any other input
  end

endmodule

// File: dv/robTb.sv
// Self-checking testbench for the reorder buffer, applies a stimulus table against a queue model
`timescale 1ns/1ns
`include "robDefines.svh"

module robTb;

  localparam logic [1:0]  skipLookup = 2'd0;  // Lookup port not checked in this row
  localparam logic [1:0]  expectMiss = 2'd1;  // Entry unresolved, valid low
  localparam logic [1:0]  expectHit  = 2'd2;  // Valid high, value from CDB or storage
  localparam logic [31:0] galoisTaps = 32'hd000_0001;

  typedef struct packed {
    logic             allocValid;
    robPkg::robAllocT allocData;
    logic             cdbValid;
    robPkg::robTagT   cdbTag;
    logic [2:0]       cdbFlags;    // isControl, taken, mispredict
    robPkg::robTagT   lookupTag1;
    robPkg::robTagT   lookupTag2;
    logic [1:0]       lookupExp1;
    logic [1:0]       lookupExp2;
  } stimRowT;

  logic                 clk;
  logic                 reset;
  logic                 allocValid;
  robPkg::robAllocT     allocData;
  cdbPkg::cdbBroadcastT cdb;
  robPkg::robTagT       lookupTag1;
  robPkg::robTagT       lookupTag2;
  robPkg::robTagT       allocTag;
  logic                 full;
  logic [`XLEN-1:0]     lookupValue1;
  logic                 lookupValid1;
  logic [`XLEN-1:0]     lookupValue2;
  logic                 lookupValid2;
  robPkg::robCommitT    commit;

  stimRowT     stimTable [$];
  logic [31:0] lfsrState  = 32'h5e29661a;
  int          cycleCount = 0;
  int          cycleLimit = 1000;  // Replaced once the table is built

  // Reference model, entries in program order
  robPkg::robTagT       modelQueue [$];
  robPkg::robTagT       modelHead;
  robPkg::robTagT       modelTail;
  logic [`ROB_DEPTH-1:0] modelReady;
  robPkg::robAllocT     modelAlloc [`ROB_DEPTH];
  cdbPkg::cdbBroadcastT modelStored [`ROB_DEPTH];  // Last broadcast per entry
  robPkg::robCommitT    expCommit;                 // Record due after the last edge

  robClockGen clockGen0 (.clk, .reset);

  reorderBuffer dut0 (
    .clk, .reset, .allocValid, .allocData, .cdb, .lookupTag1, .lookupTag2,
    .allocTag, .full, .lookupValue1, .lookupValid1, .lookupValue2, .lookupValid2, .commit
  );

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, the stimulus loop never finished", cycleCount);
      failRun("timeout");
    end
  end

  task automatic failRun(input string reason);
    $display(">>> FAIL");
    $fatal(1, "Run stopped on %s", reason);
  endtask

  task automatic reportMismatch(input string name, input string expText, input string actText);
    $display("** Error at %0t ns: %s expected %s, got %s", $time, name, expText, actText);
    failRun(name);
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] nextRandom(input int nBits);
    logic [31:0] value;
    logic        outBit;
    int          i;
    value = '0;
    for (i = 0; i < nBits; i++) begin
      outBit    = lfsrState[0];
      lfsrState = (lfsrState >> 1) ^ (outBit ? galoisTaps : 32'h0);
      value     = {value[30:0], outBit};
    end
    return value;
  endfunction

  task automatic checkCommit(input robPkg::robCommitT act, input robPkg::robCommitT expRec);
    logic [7:0] actFlags;
    actFlags = {act.valid, act.ctrl, act.isControl, act.taken, act.mispredict};
    if (expRec.valid) begin
      if (act !== expRec) begin
        reportMismatch("commit", $sformatf("%h", expRec), $sformatf("%h", act));
      end
    end else if (actFlags !== 8'h00) begin  // Idle cycle, only state-changing fields matter
      reportMismatch("commit.valid/ctrl/flags", "00", $sformatf("%h", actFlags));
    end
  endtask

  task automatic checkLookup(input string name, input logic [`XLEN-1:0] actValue,
                             input logic actValid, input logic [`XLEN-1:0] expValue,
                             input logic expValid);
    if (actValid !== expValid) begin
      reportMismatch({name, "Valid"}, $sformatf("%b", expValid), $sformatf("%b", actValid));
    end
    if (expValid && actValue !== expValue) begin
      reportMismatch({name, "Value"}, $sformatf("%h", expValue), $sformatf("%h", actValue));
    end
  endtask

  task automatic checkAlloc(input robPkg::robTagT actTag, input logic actFull,
                            input robPkg::robTagT expTag, input logic expFull);
    if (actTag !== expTag) begin
      reportMismatch("allocTag", $sformatf("%0d", expTag), $sformatf("%0d", actTag));
    end
    if (actFull !== expFull) begin
      reportMismatch("full", $sformatf("%b", expFull), $sformatf("%b", actFull));
    end
  endtask

  // Expected value is the CDB result on a bypass, else the stored one
  task automatic checkLookupPort(input logic [1:0] code, input robPkg::robTagT tag,
                                 input logic [`XLEN-1:0] actValue, input logic actValid,
                                 input string name);
    logic             hit;
    logic [`XLEN-1:0] expValue;
    hit      = cdb.valid && (cdb.tag == tag);
    expValue = hit ? cdb.result : modelStored[tag].result;
    if (code != skipLookup) checkLookup(name, actValue, actValid, expValue, code == expectHit);
  endtask

  task automatic addRow(input logic aV, input logic [`ARCH_REG_W-1:0] dest,
                        input logic [`XLEN-1:0] pc, input robPkg::robCtrlT ctrl,
                        input logic cV, input robPkg::robTagT cTag, input logic [2:0] flags,
                        input robPkg::robTagT lt1, input robPkg::robTagT lt2,
                        input logic [1:0] e1, input logic [1:0] e2);
    stimRowT row;
    row.allocValid         = aV;
    row.allocData.destReg  = dest;
    row.allocData.instrPc  = pc;
    row.allocData.phtIndex = pc[`PHT_INDEX_W+1:2];  // Gshare index from low PC bits
    row.allocData.ctrl     = ctrl;
    row.cdbValid           = cV;
    row.cdbTag             = cTag;
    row.cdbFlags           = flags;
    row.lookupTag1         = lt1;
    row.lookupTag2         = lt2;
    row.lookupExp1         = e1;
    row.lookupExp2         = e2;
    stimTable.push_back(row);
  endtask

  task automatic addAlloc(input logic [`ARCH_REG_W-1:0] dest, input logic [`XLEN-1:0] pc,
                          input robPkg::robCtrlT ctrl);
    addRow(1'b1, dest, pc, ctrl, '0, '0, '0, '0, '0, skipLookup, skipLookup);
  endtask

  task automatic addResolve(input robPkg::robTagT tag, input logic [2:0] flags,
                            input robPkg::robTagT lt1, input robPkg::robTagT lt2,
                            input logic [1:0] e1, input logic [1:0] e2);
    addRow('0, '0, '0, '0, 1'b1, tag, flags, lt1, lt2, e1, e2);
  endtask

  task automatic addIdle(input int n);
    repeat (n) addRow('0, '0, '0, '0, '0, '0, '0, '0, '0, skipLookup, skipLookup);
  endtask

  task automatic buildTable();
    int k;
    // Results arrive 2, 1, 0 but commit in order 0, 1, 2
    addAlloc(5'd1, 32'h1000, 4'b1000);
    addAlloc(5'd2, 32'h1004, 4'b1000);
    addAlloc(5'd3, 32'h1008, 4'b0010);
    addResolve(3'd2, 3'b110, 3'd0, 3'd2, expectMiss, expectHit);
    addResolve(3'd1, 3'b000, 3'd2, 3'd1, expectHit, expectHit);   // Stored and bypassed
    addResolve(3'd0, 3'b000, 3'd1, 3'd0, expectHit, expectHit);   // Head bypass on entry 0
    addIdle(3);
    // Single jump, broadcast straight to the head
    addAlloc(5'd4, 32'h100c, 4'b1001);
    addResolve(3'd3, 3'b110, 3'd3, 3'd3, expectHit, expectHit);
    addIdle(1);
    // Fill all entries, tags 4 to 3, entry 6 is the branch
    for (k = 0; k < `ROB_DEPTH; k++) begin
      addAlloc(5'(8 + k), 32'h2000 + 32'(4 * k),
               (k == 2) ? 4'b0010 : ((k == 3) ? 4'b0100 : 4'b1000));
    end
    addRow(1'b1, 5'd20, 32'h3000, 4'b1000, '0, '0, '0, 3'd5, 3'd4, expectMiss, expectMiss);
    addRow(1'b1, 5'd21, 32'h3004, 4'b1000, 1'b1, 3'd0, 3'b000, '0, '0, skipLookup, skipLookup);
    addResolve(3'd5, 3'b000, 3'd0, 3'd5, expectHit, expectHit);
    addResolve(3'd4, 3'b100, '0, '0, skipLookup, skipLookup);
    addResolve(3'd6, 3'b101, '0, '0, skipLookup, skipLookup);   // Mispredicted branch
    addResolve(3'd7, 3'b000, '0, '0, skipLookup, skipLookup);   // Younger, must be dropped
    // Refill after the flush
    addAlloc(5'd22, 32'h4000, 4'b1000);
    addRow(1'b1, 5'd23, 32'h4004, 4'b1000, '0, '0, '0, 3'd7, 3'd7, expectMiss, expectMiss);
    addResolve(3'd0, 3'b000, 3'd0, 3'd7, expectHit, expectMiss);
    addRow(1'b1, 5'd24, 32'h4008, 4'b0100, 1'b1, 3'd7, 3'b000, 3'd0, 3'd7, expectHit, expectHit);
    addResolve(3'd1, 3'b000, '0, '0, skipLookup, skipLookup);
    addIdle(3);
  endtask

  task automatic driveRow(input stimRowT row);
    allocValid = row.allocValid;
    allocData  = row.allocData;
    cdb        = '0;
    if (row.cdbValid) begin
      cdb.valid  = 1'b1;
      cdb.tag    = row.cdbTag;
      cdb.result = nextRandom(32);
      {cdb.isControl, cdb.taken, cdb.mispredict} = row.cdbFlags;
      cdb.targetAddress = nextRandom(32) & 32'hffff_fffc;  // Word aligned
    end
    lookupTag1 = row.lookupTag1;
    lookupTag2 = row.lookupTag2;
  endtask

  // Applies the driven inputs to the model for the coming edge
  task automatic predictEdge();
    robPkg::robTagT       head;
    logic                 bypass;
    logic                 headReady;
    cdbPkg::cdbBroadcastT src;
    head      = modelHead;
    bypass    = cdb.valid && (cdb.tag == head);
    headReady = (modelQueue.size() != 0) && (modelReady[head] || bypass);
    src       = bypass ? cdb : modelStored[head];
    expCommit = '0;
    if (headReady) begin
      expCommit.valid         = 1'b1;
      expCommit.tag           = head;
      expCommit.destReg       = modelAlloc[head].destReg;
      expCommit.ctrl          = modelAlloc[head].ctrl;
      expCommit.instrPc       = modelAlloc[head].instrPc;
      expCommit.phtIndex      = modelAlloc[head].phtIndex;
      expCommit.result        = src.result;
      expCommit.isControl     = src.isControl;
      expCommit.taken         = src.taken;
      expCommit.mispredict    = src.mispredict;
      expCommit.targetAddress = src.targetAddress;
    end
    if (allocValid && modelQueue.size() < `ROB_DEPTH) begin  // Dropped while full
      modelAlloc[modelTail] = allocData;
      modelReady[modelTail] = 1'b0;
      modelQueue.push_back(modelTail);
      modelTail = modelTail + robPkg::robTagT'(1);
    end
    if (cdb.valid) begin
      modelStored[cdb.tag] = cdb;
      modelReady[cdb.tag]  = 1'b1;
    end
    if (headReady) begin
      modelReady[head] = 1'b0;
      void'(modelQueue.pop_front());
      modelHead = head + robPkg::robTagT'(1);
      if (src.mispredict) begin  // Younger entries vanish, tail follows the head
        modelQueue.delete();
        modelTail = modelHead;
      end
    end
  endtask

  initial begin
    allocValid = 1'b0;
    allocData  = '0;
    cdb        = '0;
    lookupTag1 = '0;
    lookupTag2 = '0;
    modelHead  = '0;
    modelTail  = '0;
    modelReady = '0;
    expCommit  = '0;
    buildTable();
    cycleLimit = stimTable.size() * 4 + 50;
    wait (reset === 1'b1);
    #1;
    checkCommit(commit, '0);  // Reset state
    checkAlloc(allocTag, full, '0, 1'b0);
    foreach (stimTable[i]) begin
      @(posedge clk);
      #2 driveRow(stimTable[i]);
      #1;
      checkCommit(commit, expCommit);
      checkAlloc(allocTag, full, modelTail, modelQueue.size() == `ROB_DEPTH);
      checkLookupPort(stimTable[i].lookupExp1, lookupTag1, lookupValue1, lookupValid1, "lookup1");
      checkLookupPort(stimTable[i].lookupExp2, lookupTag2, lookupValue2, lookupValid2, "lookup2");
      predictEdge();
    end
    @(posedge clk);
    #3 checkCommit(commit, expCommit);  // Edge after the last row
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: reorderBuffer.f
+incdir+src
src/robPkg.sv
src/cdbPkg.sv
src/robAllocator.sv
src/robStorage.sv
src/robCommit.sv
src/reorderBuffer.sv
dv/robClockGen.sv
dv/robTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the reorder buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module robTb -f reorderBuffer.f -Mdir obj_dir -o robSim

# A $fatal in the testbench gives a non-zero exit status here
./obj_dir/robSim
